// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Cache geometry
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int WORD_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 32;

    // Address split widths
    localparam int WORD_OFFSET_BITS  = $clog2(WORD_WIDTH / 8);   // Byte within word
    localparam int BLOCK_OFFSET_BITS = $clog2(BLOCK_WORDS);      // Word within block
    localparam int OFFSET_BITS       = WORD_OFFSET_BITS + BLOCK_OFFSET_BITS;
    localparam int SET_BITS          = $clog2(NUM_SETS);
    localparam int WAY_BITS          = $clog2(NUM_WAYS);
    localparam int TAG_BITS          = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

    // Address layout, high to low
    // tag | set | word | byte

    typedef logic [SET_BITS-1:0]          set_idx_t;
    typedef logic [WAY_BITS-1:0]          way_idx_t;
    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [BLOCK_OFFSET_BITS-1:0] word_idx_t;
    typedef logic [WORD_WIDTH-1:0]        word_t;

    // Whole cache line, word 0 in the low bits
    typedef word_t [BLOCK_WORDS-1:0] block_t;

    // Fetch controller states
    typedef enum logic [1:0] {
        IDLE,
        REFILL,       // Waiting on memory burst
        FILL_WRITE,   // One-cycle array write
        RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/array_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Block write from the refill path into the tag and data arrays
interface array_wr_if;
    import icache_pkg::*;

    logic     en;      // Single-cycle write strobe
    set_idx_t set;
    way_idx_t way;
    tag_t     tag;     // Tag array only
    block_t   block;   // Data array only

    modport ctrl (
        output en,
        output set,
        output way,
        output tag,
        output block
    );

    modport array (
        input en,
        input set,
        input way,
        input tag,
        input block
    );

endinterface

`default_nettype wire

// ==== src/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
    input  logic                 Clk,
    input  logic                 rst_n,
    input  icache_pkg::set_idx_t lookup_set,
    input  icache_pkg::tag_t     lookup_tag,
    output logic                 hit,
    output icache_pkg::way_idx_t hit_way,
    output icache_pkg::way_idx_t victim_way,
    array_wr_if.array            wr
);
    import icache_pkg::*;

    logic [NUM_WAYS-1:0] valid  [NUM_SETS];   // One bit per way
    tag_t                tags   [NUM_SETS][NUM_WAYS];
    way_idx_t            rr_ptr [NUM_SETS];   // Round-robin victim when set is full

    // Parallel compare across all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[lookup_set][w] && (tags[lookup_set][w] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    // Lowest invalid way wins, pointer otherwise
    always_comb begin
        victim_way = rr_ptr[lookup_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[lookup_set][w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    // Valid bits and pointers
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (wr.en) begin
            valid[wr.set][wr.way] <= 1'b1;
            // Only a replacement in a full set moves the pointer
            if (&valid[wr.set]) begin
                rr_ptr[wr.set] <= rr_ptr[wr.set] + 1'b1;
            end
        end
    end

    // Tag storage, qualified by valid
    always_ff @(posedge Clk) begin
        if (wr.en) begin
            tags[wr.set][wr.way] <= wr.tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
    input  logic                  Clk,
    input  icache_pkg::set_idx_t  rd_set,
    input  icache_pkg::way_idx_t  rd_way,
    input  icache_pkg::word_idx_t rd_word,
    output icache_pkg::word_t     rd_data,
    array_wr_if.array             wr
);
    import icache_pkg::*;

    block_t lines [NUM_SETS][NUM_WAYS];

    // Word select straight out of the addressed line
    assign rd_data = lines[rd_set][rd_way][rd_word];

    // Whole line written at once after a refill
    always_ff @(posedge Clk) begin
        if (wr.en) begin
            lines[wr.set][wr.way] <= wr.block;
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                  Clk,
    input  logic                  rst_n,

    input  logic                  read_enable,
    input  icache_pkg::word_t     read_address,
    output icache_pkg::word_t     instruction,
    output logic                  ready,
    output logic                  busy,

    output icache_pkg::set_idx_t  lookup_set,
    output icache_pkg::tag_t      lookup_tag,
    output icache_pkg::word_idx_t lookup_word,
    input  logic                  hit,
    input  icache_pkg::way_idx_t  hit_way,
    input  icache_pkg::way_idx_t  victim_way,
    input  icache_pkg::word_t     hit_data,

    output icache_pkg::word_t     mem_read_address,
    output logic                  mem_read_request,
    input  icache_pkg::word_t     mem_data_in,
    input  logic                  mem_data_ready,

    array_wr_if.ctrl              wr
);
    import icache_pkg::*;

    ctrl_state_e state;
    word_idx_t   word_cnt;     // Next burst word

    // Request fields held through a refill
    tag_t        miss_tag;
    set_idx_t    miss_set;
    word_idx_t   miss_word;
    way_idx_t    acc_way;      // Way of current access, victim on a miss
    block_t      fill_block;

    logic        accept;
    logic        burst_beat;
    logic        last_beat;

    // Fetch address split
    assign lookup_tag  = read_address[ADDR_WIDTH-1 -: TAG_BITS];
    assign lookup_set  = read_address[OFFSET_BITS +: SET_BITS];
    assign lookup_word = read_address[WORD_OFFSET_BITS +: BLOCK_OFFSET_BITS];

    assign accept     = (state == IDLE) && read_enable;
    assign burst_beat = (state == REFILL) && mem_data_ready;
    assign last_beat  = burst_beat && (word_cnt == word_idx_t'(BLOCK_WORDS - 1));

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= IDLE;
            instruction      <= '0;
            ready            <= 1'b0;
            busy             <= 1'b0;
            mem_read_address <= '0;
            mem_read_request <= 1'b0;
            word_cnt         <= '0;
        end else begin
            ready <= 1'b0;   // Response is a single pulse
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (hit) begin
                            instruction <= hit_data;
                            ready       <= 1'b1;
                            state       <= RESPOND;
                        end else begin
                            // Block-aligned burst request
                            mem_read_address <= {read_address[ADDR_WIDTH-1:OFFSET_BITS],
                                                 {OFFSET_BITS{1'b0}}};
                            mem_read_request <= 1'b1;
                            busy             <= 1'b1;
                            word_cnt         <= '0;
                            state            <= REFILL;
                        end
                    end
                end

                REFILL: begin
                    if (burst_beat) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        mem_read_request <= 1'b0;
                        state            <= FILL_WRITE;
                    end
                end

                FILL_WRITE: begin
                    // Arrays take the line on this edge
                    instruction <= fill_block[miss_word];
                    ready       <= 1'b1;
                    busy        <= 1'b0;
                    state       <= RESPOND;
                end

                RESPOND: state <= IDLE;

                default: state <= IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge Clk) begin
        if (accept) begin
            miss_tag  <= lookup_tag;
            miss_set  <= lookup_set;
            miss_word <= lookup_word;
            acc_way   <= hit ? hit_way : victim_way;
        end
        if (burst_beat) begin
            fill_block[word_cnt] <= mem_data_in;   // Words arrive in address order
        end
    end

    // One write per refill
    assign wr.en    = (state == FILL_WRITE);
    assign wr.set   = miss_set;
    assign wr.way   = acc_way;
    assign wr.tag   = miss_tag;
    assign wr.block = fill_block;

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic              Clk,
    input  logic              rst_n,

    // Core fetch side
    input  logic              read_enable,
    input  icache_pkg::word_t read_address,
    output icache_pkg::word_t instruction,
    output logic              ready,
    output logic              busy,

    // Memory controller side
    output icache_pkg::word_t mem_read_address,
    output logic              mem_read_request,
    input  icache_pkg::word_t mem_data_in,
    input  logic              mem_data_ready
);
    import icache_pkg::*;

    set_idx_t  lookup_set;
    tag_t      lookup_tag;
    word_idx_t lookup_word;
    logic      hit;
    way_idx_t  hit_way;
    way_idx_t  victim_way;
    word_t     hit_data;

    array_wr_if wr_bus ();

    icache_ctrl u_ctrl (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .lookup_set       (lookup_set),
        .lookup_tag       (lookup_tag),
        .lookup_word      (lookup_word),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .hit_data         (hit_data),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .wr               (wr_bus.ctrl)
    );

    icache_tag_array u_tag_array (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .wr         (wr_bus.array)
    );

    // Hit way selects the line to read
    icache_data_array u_data_array (
        .Clk     (Clk),
        .rd_set  (lookup_set),
        .rd_way  (hit_way),
        .rd_word (lookup_word),
        .rd_data (hit_data),
        .wr      (wr_bus.array)
    );

endmodule

`default_nettype wire

// ==== verification/icache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// SDRAM controller stand-in, one block burst per request with random stalls
module icache_mem_model #(
    parameter int          GAP_PERCENT = 30,
    parameter logic [31:0] SEED        = 32'hc833
) (
    input  logic              Clk,
    input  logic              rst_n,
    input  icache_pkg::word_t mem_read_address,
    input  logic              mem_read_request,
    output icache_pkg::word_t mem_data_in,
    output logic              mem_data_ready
);
    import icache_pkg::*;

    logic [31:0] rng_state;
    int          sent;        // Words already handed out for this block

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory contents as a function of the full byte address
    function automatic word_t mem_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h0bad_c0de;
    endfunction

    initial begin
        rng_state      = SEED;
        sent           = 0;
        mem_data_in    = '0;
        mem_data_ready = 1'b0;
    end

    always @(posedge Clk) begin
        if (!rst_n || !mem_read_request) begin
            sent           <= 0;
            mem_data_ready <= 1'b0;
        end else if (sent < BLOCK_WORDS) begin
            rng_state <= lcg_next(rng_state);
            // Upper LCG bits decide whether this cycle is a gap
            if ((rng_state[31:16] % 100) >= GAP_PERCENT) begin
                mem_data_in    <= mem_word(mem_read_address + 32'(sent * (WORD_WIDTH / 8)));
                mem_data_ready <= 1'b1;
                sent           <= sent + 1;
            end else begin
                mem_data_ready <= 1'b0;
            end
        end else begin
            mem_data_ready <= 1'b0;   // Burst done, wait for request to drop
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam logic [31:0] SEED           = 32'hc833;
    localparam int          GAP_PERCENT    = 30;
    localparam int          FETCH_TIMEOUT  = 200;            // Cycles per fetch
    localparam int          RANDOM_FETCHES = 300;
    localparam logic [31:0] RANDOM_MASK    = 32'h0000_03fc;  // 64 blocks onto 32 lines

    logic  Clk;
    logic  rst_n;
    logic  read_enable;
    word_t read_address;
    word_t instruction;
    logic  ready;
    logic  busy;
    word_t mem_read_address;
    logic  mem_read_request;
    word_t mem_data_in;
    logic  mem_data_ready;

    // Expected cache state
    logic     ref_valid [NUM_SETS][NUM_WAYS];
    tag_t     ref_tag   [NUM_SETS][NUM_WAYS];
    way_idx_t ref_ptr   [NUM_SETS];

    logic [31:0] rng_state;
    logic        request_q;
    int          errors;
    int          responses;
    int          mem_requests;
    int          predicted_misses;

    icache_top uut (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    icache_mem_model #(.GAP_PERCENT(GAP_PERCENT), .SEED(SEED)) u_mem (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected memory word at a byte address
    function automatic word_t mem_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h0bad_c0de;
    endfunction

    // First byte address of the block that holds addr
    function automatic word_t block_base(input word_t addr);
        return addr & ~word_t'(BLOCK_WORDS * (WORD_WIDTH / 8) - 1);
    endfunction

    // Returns 1 on a predicted hit and refills the reference state on a miss
    function automatic logic predict_access(input word_t addr);
        set_idx_t s;
        tag_t     t;
        int       victim;
        logic     found;
        s      = addr[OFFSET_BITS +: SET_BITS];
        t      = addr[ADDR_WIDTH-1 -: TAG_BITS];
        found  = 1'b0;
        victim = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) found = 1'b1;
        end
        if (!found) begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[s][w]) victim = w;   // Lowest invalid way
            end
            if (victim < 0) begin
                victim     = ref_ptr[s];
                ref_ptr[s] = ref_ptr[s] + 1'b1;
            end
            ref_valid[s][victim] = 1'b1;
            ref_tag[s][victim]   = t;
        end
        return found;
    endfunction

    // Tag 0x100 + n in set 6
    function automatic word_t evict_addr(input int n);
        return word_t'((32'h100 + n) << (OFFSET_BITS + SET_BITS)) | word_t'(6 << OFFSET_BITS);
    endfunction

    task automatic print_counts();
        $display("Errors %0d, responses %0d, memory requests %0d, predicted misses %0d",
                 errors, responses, mem_requests, predicted_misses);
    endtask

    task automatic abort_run(input string reason);
        errors++;
        $display("%s", reason);
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    endtask

    // Response and memory request checker
    always @(posedge Clk) begin
        if (ready) begin
            responses++;
            assert (instruction === mem_word({read_address[31:2], 2'b00})) else begin
                errors++;
                $display("mismatch instruction at %h: got %h, expected %h", read_address,
                         instruction, mem_word({read_address[31:2], 2'b00}));
            end
        end
        if (mem_read_request && !request_q) begin
            mem_requests++;
            assert (mem_read_address === block_base(read_address))
            else begin
                errors++;
                $display("mismatch mem_read_address: got %h, expected %h", mem_read_address,
                         block_base(read_address));
            end
        end
        request_q <= mem_read_request;
    end

    task automatic fetch(input word_t addr, output logic was_hit);
        int   cycles;
        int   requests_before;
        logic expect_hit;
        expect_hit      = predict_access(addr);
        predicted_misses += expect_hit ? 0 : 1;
        requests_before = mem_requests;
        @(posedge Clk);
        read_enable  <= 1'b1;
        read_address <= addr;
        cycles = 0;
        do begin
            @(posedge Clk);
            cycles++;
            if (!ready && cycles >= 2) begin
                assert (busy === !expect_hit) else begin
                    errors++;
                    $display("mismatch busy at %h: got %h, expected %h", addr, busy, !expect_hit);
                end
            end
        end while (!ready && cycles < FETCH_TIMEOUT);
        read_enable <= 1'b0;
        if (!ready) begin
            abort_run($sformatf("No response to the fetch of %h in time", addr));
        end else begin
            was_hit = (mem_requests == requests_before);
            assert (was_hit == expect_hit) else begin
                errors++;
                $display("mismatch hit at %h: got %h, expected %h", addr, was_hit, expect_hit);
            end
            if (expect_hit) begin
                assert (cycles == 2) else begin
                    errors++;
                    $display("Hit at %h answered %0d cycles after sampling, not 1", addr,
                             cycles - 1);
                end
            end
        end
    endtask

    initial begin
        logic h;
        rst_n            = 1'b0;
        read_enable      = 1'b0;
        read_address     = '0;
        rng_state        = SEED;
        request_q        = 1'b0;
        errors           = 0;
        responses        = 0;
        mem_requests     = 0;
        predicted_misses = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_ptr[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) ref_valid[s][w] = 1'b0;
        end
        repeat (8) @(posedge Clk);
        rst_n <= 1'b1;
        @(posedge Clk);

        assert (ready === 1'b0 && busy === 1'b0 && mem_read_request === 1'b0) else begin
            errors++;
            $display("Control outputs are not low after reset");
        end
        assert (instruction === '0) else begin
            errors++;
            $display("mismatch instruction after reset: got %h, expected %h", instruction, 32'h0);
        end

        fetch(32'h0000_1238, h);   // Cold miss on the middle word
        for (int w = 0; w < BLOCK_WORDS; w++) fetch(32'h0000_1230 + 32'(w * 4), h);

        // Fill set 6 and then force a round-robin eviction of way 0
        for (int n = 0; n < 5; n++) fetch(evict_addr(n), h);
        for (int n = 1; n < 5; n++) begin
            fetch(evict_addr(n), h);
            assert (h) else begin
                errors++;
                $display("Tag %0d of set 6 was lost by the eviction", n);
            end
        end
        fetch(evict_addr(0), h);
        assert (!h) else begin
            errors++;
            $display("Evicted tag of set 6 still hit");
        end

        repeat (RANDOM_FETCHES) begin
            rng_state = lcg_next(rng_state);
            fetch(word_t'(rng_state[31:16]) & RANDOM_MASK, h);
        end

        repeat (4) @(posedge Clk);
        assert (mem_requests == predicted_misses) else begin
            errors++;
            $display("mismatch mem_requests: got %h, expected %h", mem_requests, predicted_misses);
        end
        print_counts();
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/icache_pkg.sv
src/array_wr_if.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_ctrl.sv
src/icache_top.sv
verification/icache_mem_model.sv
verification/tb_icache.sv
